/* hw/rv_id_ex_cfg.svh */
`ifndef RV_ID_EX_CFG_SVH
`define RV_ID_EX_CFG_SVH

// Integer register and datapath width
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_REG_COUNT 32

// First fetch address after reset
`define RV_PC_RESET 32'h0000_0000

`endif

/* hw/rv_id_ex_pkg.sv */
`include "rv_id_ex_cfg.svh"

package rv_id_ex_pkg;

    // Major opcodes of the supported instruction classes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } rv_alu_op_e;

    // First ALU operand source
    typedef enum logic [1:0] {
        ALU_A_RS1  = 2'd0,
        ALU_A_PC   = 2'd1,
        ALU_A_ZERO = 2'd2
    } rv_alu_a_src_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_fmt_t;

    // Store and branch share the split immediate layout
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } rv_sb_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_uj_fmt_t;

    // One instruction word seen in every encoding format
    typedef union packed {
        rv_r_fmt_t  r_type;
        rv_i_fmt_t  i_type;
        rv_sb_fmt_t sb_type;
        rv_uj_fmt_t uj_type;
    } rv_instr_u;

    typedef struct packed {
        logic          valid;
        logic          reg_write;
        rv_alu_a_src_e alu_a_src;
        logic          alu_b_src;      // 1 selects the immediate
        rv_alu_op_e    alu_op;
        logic          is_branch;
        logic          is_jump;
        logic          jb_target_src;  // 1 selects rs1 (JALR)
        logic          link;
    } rv_id_ctrl_t;

    typedef struct packed {
        rv_instr_u             instr;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [2:0]            funct3;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   pc_plus4;
        logic                  rs_eq_lo;
        logic                  rs_lt_u_lo;
        logic                  rs_lt_s_lo;
        logic                  rs_sign_a;
        logic                  rs_sign_b;
    } rv_id_data_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } rv_wb_t;

    typedef struct packed {
        logic                taken;
        logic [`RV_XLEN-1:0] target;
    } rv_redirect_t;

endpackage

/* hw/rv_decode_stage.sv */
`include "rv_id_ex_cfg.svh"

module rv_decode_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  logic [31:0]                instr,
    input  rv_id_ex_pkg::rv_wb_t       wb,
    input  rv_id_ex_pkg::rv_redirect_t redirect,
    output logic [`RV_XLEN-1:0]        fetch_pc,
    output rv_id_ex_pkg::rv_id_ctrl_t  id_ctrl,
    output rv_id_ex_pkg::rv_id_data_t  id_data
);

    localparam int HALF = `RV_XLEN / 2;
    localparam logic [`RV_XLEN-1:0] PC_STEP = 4;

    logic [`RV_XLEN-1:0]     pc;
    logic [`RV_XLEN-1:0]     regs [`RV_REG_COUNT];
    rv_id_ex_pkg::rv_instr_u ins;
    logic [`RV_XLEN-1:0]     imm_i;
    logic [`RV_XLEN-1:0]     imm_b;
    logic [`RV_XLEN-1:0]     imm_u;
    logic [`RV_XLEN-1:0]     imm_j;
    logic [`RV_XLEN-1:0]     imm;
    logic [`RV_XLEN-1:0]     rs1_val;
    logic [`RV_XLEN-1:0]     rs2_val;
    logic                    f7_zero;
    logic                    f7_alt;
    logic                    fwd_rs1;
    logic                    fwd_rs2;

    function automatic rv_id_ex_pkg::rv_alu_op_e alu_op_of(
        input logic [2:0] funct3,
        input logic       alt
    );
        rv_id_ex_pkg::rv_alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? rv_id_ex_pkg::ALU_SUB : rv_id_ex_pkg::ALU_ADD;
            3'b001:  op = rv_id_ex_pkg::ALU_SLL;
            3'b010:  op = rv_id_ex_pkg::ALU_SLT;
            3'b011:  op = rv_id_ex_pkg::ALU_SLTU;
            3'b100:  op = rv_id_ex_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_id_ex_pkg::ALU_SRA : rv_id_ex_pkg::ALU_SRL;
            3'b110:  op = rv_id_ex_pkg::ALU_OR;
            default: op = rv_id_ex_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // Fetch PC, a redirect wins over stall
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_PC_RESET;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else if (!stall) begin
            pc <= pc + PC_STEP;
        end
    end

    assign fetch_pc = pc;

    // Register file, x0 stays zero because it is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign ins = instr;

    assign imm_i = {{(`RV_XLEN-12){ins.i_type.imm12[11]}}, ins.i_type.imm12};
    assign imm_b = {{(`RV_XLEN-13){ins.sb_type.imm_hi[6]}}, ins.sb_type.imm_hi[6],
                    ins.sb_type.imm_lo[0], ins.sb_type.imm_hi[5:0],
                    ins.sb_type.imm_lo[4:1], 1'b0};
    assign imm_u = {ins.uj_type.imm20, 12'b0};
    assign imm_j = {{(`RV_XLEN-21){ins.uj_type.imm20[19]}}, ins.uj_type.imm20[19],
                    ins.uj_type.imm20[7:0], ins.uj_type.imm20[8],
                    ins.uj_type.imm20[18:9], 1'b0};

    assign f7_zero = ins.r_type.funct7 == 7'b0000000;
    assign f7_alt  = ins.r_type.funct7 == 7'b0100000;

    // Result of the instruction now in EX bypasses the register file
    assign fwd_rs1 = wb.valid && wb.rd != 5'd0 && wb.rd == ins.r_type.rs1;
    assign fwd_rs2 = wb.valid && wb.rd != 5'd0 && wb.rd == ins.r_type.rs2;
    assign rs1_val = fwd_rs1 ? wb.data : regs[ins.r_type.rs1];
    assign rs2_val = fwd_rs2 ? wb.data : regs[ins.r_type.rs2];

    always_comb begin
        id_ctrl = '0;
        imm     = '0;
        case (ins.r_type.opcode)
            rv_id_ex_pkg::OPC_OP: begin
                id_ctrl.valid  = f7_zero || (f7_alt && ins.r_type.funct3 inside {3'b000, 3'b101});
                id_ctrl.alu_op = alu_op_of(ins.r_type.funct3, f7_alt);
            end
            rv_id_ex_pkg::OPC_OP_IMM: begin
                case (ins.r_type.funct3)
                    3'b001:  id_ctrl.valid = f7_zero;
                    3'b101:  id_ctrl.valid = f7_zero || f7_alt;
                    default: id_ctrl.valid = 1'b1;
                endcase
                // Only the shift-right immediate has an alternate form
                id_ctrl.alu_op    = alu_op_of(ins.r_type.funct3,
                                              ins.r_type.funct3 == 3'b101 && f7_alt);
                id_ctrl.alu_b_src = 1'b1;
                imm               = imm_i;
            end
            rv_id_ex_pkg::OPC_LUI: begin
                id_ctrl.valid     = 1'b1;
                id_ctrl.alu_a_src = rv_id_ex_pkg::ALU_A_ZERO;
                id_ctrl.alu_b_src = 1'b1;
                id_ctrl.alu_op    = rv_id_ex_pkg::ALU_PASS_B;
                imm               = imm_u;
            end
            rv_id_ex_pkg::OPC_AUIPC: begin
                id_ctrl.valid     = 1'b1;
                id_ctrl.alu_a_src = rv_id_ex_pkg::ALU_A_PC;
                id_ctrl.alu_b_src = 1'b1;
                imm               = imm_u;
            end
            rv_id_ex_pkg::OPC_JAL: begin
                id_ctrl.valid   = 1'b1;
                id_ctrl.is_jump = 1'b1;
                id_ctrl.link    = 1'b1;
                imm             = imm_j;
            end
            rv_id_ex_pkg::OPC_JALR: begin
                id_ctrl.valid         = ins.i_type.funct3 == 3'b000;
                id_ctrl.is_jump       = 1'b1;
                id_ctrl.link          = 1'b1;
                id_ctrl.jb_target_src = 1'b1;
                imm                   = imm_i;
            end
            rv_id_ex_pkg::OPC_BRANCH: begin
                // funct3 010 and 011 are not branch conditions
                id_ctrl.valid     = ins.sb_type.funct3[2:1] != 2'b01;
                id_ctrl.is_branch = 1'b1;
                imm               = imm_b;
            end
            default: begin
                id_ctrl.valid = 1'b0;
            end
        endcase
        id_ctrl.reg_write = id_ctrl.valid && ins.r_type.opcode != rv_id_ex_pkg::OPC_BRANCH;
        // An unsupported word travels on as a bubble
        if (!id_ctrl.valid) begin
            id_ctrl = '0;
        end
    end

    always_comb begin
        id_data            = '0;
        id_data.instr      = ins;
        id_data.rd         = id_ctrl.reg_write ? ins.r_type.rd : 5'd0;
        id_data.rs1        = ins.r_type.rs1;
        id_data.rs2        = ins.r_type.rs2;
        id_data.funct3     = ins.r_type.funct3;
        id_data.rs1_data   = rs1_val;
        id_data.rs2_data   = rs2_val;
        id_data.imm        = imm;
        id_data.pc         = pc;
        id_data.pc_plus4   = pc + PC_STEP;
        // Low half of the branch compare, EX finishes it with the high half
        id_data.rs_eq_lo   = rs1_val[HALF-1:0] == rs2_val[HALF-1:0];
        id_data.rs_lt_u_lo = rs1_val[HALF-1:0] < rs2_val[HALF-1:0];
        id_data.rs_sign_a  = rs1_val[`RV_XLEN-1];
        id_data.rs_sign_b  = rs2_val[`RV_XLEN-1];
        // Differing signs settle signed less-than on their own
        id_data.rs_lt_s_lo = (id_data.rs_sign_a != id_data.rs_sign_b) ?
                             id_data.rs_sign_a : id_data.rs_lt_u_lo;
    end

endmodule

/* hw/rv_reg_id_ex.sv */
module rv_reg_id_ex (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stall,
    input  logic                      flush,
    input  rv_id_ex_pkg::rv_id_ctrl_t id_ctrl,
    input  rv_id_ex_pkg::rv_id_data_t id_data,
    output rv_id_ex_pkg::rv_id_ctrl_t ex_ctrl,
    output rv_id_ex_pkg::rv_id_data_t ex_data
);

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = {25'b0, rv_id_ex_pkg::OPC_OP_IMM};

    // Control fields, flush turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ex_ctrl <= '0;
        end else if (!stall) begin
            ex_ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        // Decode fields are cleared by flush but never by reset
        if (flush) begin
            ex_data.instr  <= NOP_WORD;
            ex_data.rd     <= '0;
            ex_data.rs1    <= '0;
            ex_data.rs2    <= '0;
            ex_data.funct3 <= '0;
        end else if (!stall) begin
            ex_data.instr  <= id_data.instr;
            ex_data.rd     <= id_data.rd;
            ex_data.rs1    <= id_data.rs1;
            ex_data.rs2    <= id_data.rs2;
            ex_data.funct3 <= id_data.funct3;
        end

        // Operands, immediate, PC and compare partials only hold on stall
        if (!stall) begin
            ex_data.rs1_data   <= id_data.rs1_data;
            ex_data.rs2_data   <= id_data.rs2_data;
            ex_data.imm        <= id_data.imm;
            ex_data.pc         <= id_data.pc;
            ex_data.pc_plus4   <= id_data.pc_plus4;
            ex_data.rs_eq_lo   <= id_data.rs_eq_lo;
            ex_data.rs_lt_u_lo <= id_data.rs_lt_u_lo;
            ex_data.rs_lt_s_lo <= id_data.rs_lt_s_lo;
            ex_data.rs_sign_a  <= id_data.rs_sign_a;
            ex_data.rs_sign_b  <= id_data.rs_sign_b;
        end
    end

endmodule

/* hw/rv_execute_stage.sv */
`include "rv_id_ex_cfg.svh"

module rv_execute_stage (
    input  logic                       stall,
    input  rv_id_ex_pkg::rv_id_ctrl_t  ex_ctrl,
    input  rv_id_ex_pkg::rv_id_data_t  ex_data,
    output rv_id_ex_pkg::rv_wb_t       wb,
    output rv_id_ex_pkg::rv_redirect_t redirect,
    output logic                       retire_valid,
    output logic [`RV_XLEN-1:0]        retire_pc,
    output logic [4:0]                 retire_rd,
    output logic [`RV_XLEN-1:0]        retire_data
);

    localparam int HALF = `RV_XLEN / 2;
    localparam int SHW  = $clog2(`RV_XLEN);

    logic                fire;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [SHW-1:0]      shamt;
    logic [`RV_XLEN-1:0] alu_res;
    logic                hi_eq;
    logic                hi_lt_u;
    logic                cmp_eq;
    logic                cmp_ltu;
    logic                cmp_lt;
    logic                br_cond;
    logic [`RV_XLEN-1:0] jb_base;
    logic [`RV_XLEN-1:0] jb_sum;
    logic [`RV_XLEN-1:0] result;

    // The slot completes only on an unstalled cycle
    assign fire = ex_ctrl.valid && !stall;

    always_comb begin
        case (ex_ctrl.alu_a_src)
            rv_id_ex_pkg::ALU_A_PC:   op_a = ex_data.pc;
            rv_id_ex_pkg::ALU_A_ZERO: op_a = '0;
            default:                  op_a = ex_data.rs1_data;
        endcase
    end

    assign op_b  = ex_ctrl.alu_b_src ? ex_data.imm : ex_data.rs2_data;
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        case (ex_ctrl.alu_op)
            rv_id_ex_pkg::ALU_ADD:    alu_res = op_a + op_b;
            rv_id_ex_pkg::ALU_SUB:    alu_res = op_a - op_b;
            rv_id_ex_pkg::ALU_SLL:    alu_res = op_a << shamt;
            rv_id_ex_pkg::ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_id_ex_pkg::ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_id_ex_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
            rv_id_ex_pkg::ALU_SRL:    alu_res = op_a >> shamt;
            rv_id_ex_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            rv_id_ex_pkg::ALU_OR:     alu_res = op_a | op_b;
            rv_id_ex_pkg::ALU_AND:    alu_res = op_a & op_b;
            rv_id_ex_pkg::ALU_PASS_B: alu_res = op_b;
            default:                  alu_res = '0;
        endcase
    end

    // High half of the compare, merged with the partials from decode
    assign hi_eq   = ex_data.rs1_data[`RV_XLEN-1:HALF] == ex_data.rs2_data[`RV_XLEN-1:HALF];
    assign hi_lt_u = ex_data.rs1_data[`RV_XLEN-1:HALF] < ex_data.rs2_data[`RV_XLEN-1:HALF];
    assign cmp_eq  = hi_eq && ex_data.rs_eq_lo;
    assign cmp_ltu = hi_lt_u || (hi_eq && ex_data.rs_lt_u_lo);
    // with equal signs, signed and unsigned order agree
    assign cmp_lt  = (ex_data.rs_sign_a != ex_data.rs_sign_b) ? ex_data.rs_lt_s_lo : cmp_ltu;

    always_comb begin
        case (ex_data.funct3)
            3'b000:  br_cond = cmp_eq;
            3'b001:  br_cond = !cmp_eq;
            3'b100:  br_cond = cmp_lt;
            3'b101:  br_cond = !cmp_lt;
            3'b110:  br_cond = cmp_ltu;
            3'b111:  br_cond = !cmp_ltu;
            default: br_cond = 1'b0;
        endcase
    end

    // JALR target clears bit 0
    assign jb_base = ex_ctrl.jb_target_src ? ex_data.rs1_data : ex_data.pc;
    assign jb_sum  = jb_base + ex_data.imm;

    assign redirect.taken  = fire && (ex_ctrl.is_jump || (ex_ctrl.is_branch && br_cond));
    assign redirect.target = {jb_sum[`RV_XLEN-1:1], jb_sum[0] & ~ex_ctrl.jb_target_src};

    // Jumps write the link address
    assign result = ex_ctrl.link ? ex_data.pc_plus4 : alu_res;

    assign wb.valid = fire && ex_ctrl.reg_write;
    assign wb.rd    = ex_data.rd;
    assign wb.data  = result;

    assign retire_valid = fire;
    assign retire_pc    = ex_data.pc;
    assign retire_rd    = ex_data.rd;
    assign retire_data  = ex_ctrl.reg_write ? result : '0;

endmodule

/* hw/rv_id_ex_core.sv */
`include "rv_id_ex_cfg.svh"

module rv_id_ex_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] fetch_pc,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data
);

    rv_id_ex_pkg::rv_id_ctrl_t  id_ctrl;
    rv_id_ex_pkg::rv_id_data_t  id_data;
    rv_id_ex_pkg::rv_id_ctrl_t  ex_ctrl;
    rv_id_ex_pkg::rv_id_data_t  ex_data;
    rv_id_ex_pkg::rv_wb_t       wb;
    rv_id_ex_pkg::rv_redirect_t redirect;

    rv_decode_stage decode_i (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .instr    (instr),
        .wb       (wb),
        .redirect (redirect),
        .fetch_pc (fetch_pc),
        .id_ctrl  (id_ctrl),
        .id_data  (id_data)
    );

    // A taken branch or jump squashes the instruction behind it
    rv_reg_id_ex reg_id_ex_i (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .flush   (redirect.taken),
        .id_ctrl (id_ctrl),
        .id_data (id_data),
        .ex_ctrl (ex_ctrl),
        .ex_data (ex_data)
    );

    rv_execute_stage execute_i (
        .stall        (stall),
        .ex_ctrl      (ex_ctrl),
        .ex_data      (ex_data),
        .wb           (wb),
        .redirect     (redirect),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

/* verif/rv_id_ex_assert.sv */
module rv_id_ex_assert (
    input logic                      clk,
    input logic                      reset,
    input logic                      stall,
    input logic                      flush,
    input rv_id_ex_pkg::rv_id_ctrl_t ex_ctrl,
    input rv_id_ex_pkg::rv_id_data_t ex_data,
    input logic                      retire_valid
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Flushed slot is a bubble
    flush_bubble: assert property (@(posedge clk) disable iff (reset)
        flush |=> !ex_ctrl.valid)
        else begin
            $error("ID/EX slot still valid after flush");
            fail_count++;
        end

    // Datapath fields hold while the pipeline is frozen
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        (stall && !flush) |=> $stable(ex_data))
        else begin
            $error("ID/EX data changed during stall");
            fail_count++;
        end

    stall_no_retire: assert property (@(posedge clk) disable iff (reset)
        stall |-> !retire_valid)
        else begin
            $error("Retirement reported during stall");
            fail_count++;
        end

endmodule

bind rv_id_ex_core rv_id_ex_assert assert_i (
    .clk          (clk),
    .reset        (reset),
    .stall        (stall),
    .flush        (redirect.taken),
    .ex_ctrl      (ex_ctrl),
    .ex_data      (ex_data),
    .retire_valid (retire_valid)
);

/* verif/rv_id_ex_checker.sv */
module rv_id_ex_checker (
    input  logic        clk,
    input  logic        reset,
    input  int          test_id,
    input  logic [31:0] prog [256],
    input  logic [31:0] fetch_pc,
    input  logic        retire_valid,
    input  logic [31:0] retire_pc,
    input  logic [4:0]  retire_rd,
    input  logic [31:0] retire_data,
    output logic        done,
    output int          err_count,
    output int          retired_total
);

    localparam logic [31:0] END_PC = 32'd596;

    logic [31:0] m_regs [32];
    logic [31:0] m_pc;
    logic        prev_reset = 1'b0;
    int          test_errs = 0;
    int          test_retired = 0;

    initial begin
        done          = 1'b0;
        err_count     = 0;
        retired_total = 0;
    end

    function automatic string test_name(input int id);
        case (id)
            0:       return "alu";
            1:       return "forward";
            2:       return "branch";
            default: return "stall";
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            test_errs++;
            err_count++;
        end
    endtask

    task automatic step_model();
        logic [31:0] w;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic [31:0] next_pc;
        w        = prog[m_pc[9:2]];
        rd       = w[11:7];
        f3       = w[14:12];
        a        = m_regs[w[19:15]];
        b        = m_regs[w[24:20]];
        imm_i    = {{20{w[31]}}, w[31:20]};
        imm_b    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u    = {w[31:12], 12'b0};
        imm_j    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        exp_rd   = 5'd0;
        exp_data = 32'd0;
        next_pc  = m_pc + 32'd4;
        case (w[6:0])
            7'h33: begin
                exp_rd   = rd;
                exp_data = alu_model(f3, w[30], a, b);
            end
            7'h13: begin
                exp_rd   = rd;
                exp_data = alu_model(f3, f3 == 3'd5 && w[30], a, imm_i);
            end
            7'h37: begin
                exp_rd   = rd;
                exp_data = imm_u;
            end
            7'h17: begin
                exp_rd   = rd;
                exp_data = m_pc + imm_u;
            end
            7'h6f: begin
                exp_rd   = rd;
                exp_data = m_pc + 32'd4;
                next_pc  = m_pc + imm_j;
            end
            7'h67: begin
                exp_rd   = rd;
                exp_data = m_pc + 32'd4;
                next_pc  = (a + imm_i) & ~32'd1;
            end
            default: begin
                if (branch_taken(f3, a, b)) begin
                    next_pc = m_pc + imm_b;
                end
            end
        endcase
        check_val("retire_pc", m_pc, retire_pc);
        check_val("retire_rd", {27'b0, exp_rd}, {27'b0, retire_rd});
        check_val("retire_data", exp_data, retire_data);
        if (exp_rd != 5'd0) begin
            m_regs[exp_rd] = exp_data;
        end
        // Reaching the self-loop closes the test
        if (m_pc == END_PC) begin
            done = 1'b1;
            $display("test %-8s retired %0d errors %0d", test_name(test_id),
                     test_retired + 1, test_errs);
        end
        m_pc = next_pc;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            if (prev_reset) begin
                check_val("fetch_pc", 32'd0, fetch_pc);
                check_val("retire_valid", 32'd0, {31'b0, retire_valid});
            end
            for (int i = 0; i < 32; i++) begin
                m_regs[i] = 32'd0;
            end
            m_pc         = 32'd0;
            done         = 1'b0;
            test_errs    = 0;
            test_retired = 0;
        end else if (retire_valid && !done) begin
            step_model();
            test_retired++;
            retired_total++;
        end
        prev_reset = reset;
    end

endmodule

/* verif/rv_id_ex_tb.sv */
module rv_id_ex_tb;

    localparam int PROG_LEN   = 150;
    localparam int MEM_WORDS  = 256;
    localparam int NUM_TESTS  = 4;
    localparam int MAX_CYCLES = 4 * PROG_LEN * 4 + 400;

    logic        clk;
    logic        reset = 1'b1;
    logic        stall = 1'b0;
    logic [31:0] instr;
    logic [31:0] fetch_pc;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic [31:0] prog [MEM_WORDS];
    logic        done;
    int          err_count;
    int          retired_total;
    int          assert_fails = 0;
    int          test_id = 0;
    int          stall_pct = 0;
    int          cycles = 0;
    int          tests_done = 0;

    // Instruction memory answers the fetch address in the same cycle
    assign instr = prog[fetch_pc[9:2]];

    rv_id_ex_core rv_id_ex_core_i (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .instr        (instr),
        .fetch_pc     (fetch_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    rv_id_ex_checker checker_i (
        .clk           (clk),
        .reset         (reset),
        .test_id       (test_id),
        .prog          (prog),
        .fetch_pc      (fetch_pc),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_rd     (retire_rd),
        .retire_data   (retire_data),
        .done          (done),
        .err_count     (err_count),
        .retired_total (retired_total)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        stall <= (stall_pct != 0) && (int'($urandom_range(0, 99)) < stall_pct);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Mode 0 is ALU only and mode 1 chains dependencies while modes 2 and 3 add control flow
    task automatic gen_program(input int mode);
        int          kind;
        int          tgt;
        int          pick;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [2:0]  f3;
        logic [11:0] imm12;
        prev_rd = 5'd0;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            kind  = (mode < 2) ? int'($urandom_range(0, 6)) : int'($urandom_range(0, 9));
            rd    = 5'($urandom_range(0, 31));
            rs1   = 5'($urandom_range(0, 31));
            rs2   = 5'($urandom_range(0, 31));
            f3    = 3'($urandom_range(0, 7));
            imm12 = 12'($urandom);
            tgt   = int'($urandom_range(i + 1, PROG_LEN - 1));
            if (mode == 1 && $urandom_range(0, 3) != 0) begin
                rs1 = prev_rd;
            end
            if (mode == 1 && $urandom_range(0, 3) != 0) begin
                rs2 = prev_rd;
            end
            case (kind)
                0, 1, 2: begin
                    if (f3 == 3'd1) begin
                        imm12 = {7'h00, imm12[4:0]};
                    end else if (f3 == 3'd5) begin
                        imm12 = {imm12[11] ? 7'h20 : 7'h00, imm12[4:0]};
                    end
                    prog[i] = {imm12, rs1, f3, rd, 7'h13};
                end
                3, 4: begin
                    prog[i] = enc_r((f3 == 3'd0 || f3 == 3'd5) && imm12[0] ? 7'h20 : 7'h00,
                                    rs2, rs1, f3, rd, 7'h33);
                end
                5: prog[i] = {imm12, 8'($urandom), rd, 7'h37};
                6: prog[i] = {imm12, 8'($urandom), rd, 7'h17};
                7: begin
                    // Skip funct3 010 and 011
                    pick    = int'($urandom_range(0, 5));
                    f3      = 3'(pick < 2 ? pick : pick + 2);
                    prog[i] = enc_b(f3, rs1, rs2, 13'((tgt - i) * 4));
                end
                8: prog[i] = enc_j(rd, 21'((tgt - i) * 4));
                default: prog[i] = {12'(tgt * 4), 5'd0, 3'd0, rd, 7'h67};
            endcase
            if (kind < 7 || kind > 7) begin
                prev_rd = rd;
            end
        end
        prog[PROG_LEN - 1] = enc_j(5'd0, 21'd0);
        for (int i = PROG_LEN; i < MEM_WORDS; i++) begin
            prog[i] = {16'hbad0, i[15:0]};
        end
    endtask

    initial begin
        void'($urandom(32'h5cf5));
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            stall_pct <= 0;
            reset     = 1'b1;
            test_id   = t;
            gen_program(t);
            repeat (5) @(negedge clk);
            reset     = 1'b0;
            stall_pct <= (t == 3) ? 30 : 0;
            while (!done) begin
                @(negedge clk);
            end
            tests_done++;
        end
        stall_pct <= 0;
        assert_fails = rv_id_ex_core_i.assert_i.fail_count;
        $display("Summary: %0d tests, %0d retirements, %0d errors, %0d assertion failures",
                 tests_done, retired_total, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* rv_id_ex.f */
+incdir+hw
hw/rv_id_ex_pkg.sv
hw/rv_decode_stage.sv
hw/rv_reg_id_ex.sv
hw/rv_execute_stage.sv
hw/rv_id_ex_core.sv
verif/rv_id_ex_assert.sv
verif/rv_id_ex_checker.sv
verif/rv_id_ex_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_id_ex.f --top-module rv_id_ex_tb -o rv_id_ex_sim

out=$(./obj_dir/rv_id_ex_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
